//--- core_isa_pkg.sv
package core_isa_pkg;

    localparam int xlen = 32;

    // ********************************************************************
    // Major opcodes
    // ********************************************************************
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_system = 7'b1110011
    } opcode_e;

    localparam logic [2:0] f3_add_sub = 3'b000;    // Register and immediate forms
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;

    localparam logic [2:0] f3_beq     = 3'b000;    // Branch conditions
    localparam logic [2:0] f3_bne     = 3'b001;
    localparam logic [2:0] f3_blt     = 3'b100;
    localparam logic [2:0] f3_bge     = 3'b101;
    localparam logic [2:0] f3_bltu    = 3'b110;
    localparam logic [2:0] f3_bgeu    = 3'b111;

    localparam logic [2:0] f3_csrrw   = 3'b001;

    localparam logic [11:0] csr_mtvec  = 12'h305;
    localparam logic [11:0] csr_mepc   = 12'h341;
    localparam logic [11:0] csr_mcause = 12'h342;

    localparam logic [xlen-1:0] cause_ecall_m = 32'd11;    // Environment call from M-mode
    localparam logic [31:0]     inst_ecall    = 32'h0000_0073;
    localparam logic [31:0]     inst_mret     = 32'h3020_0073;

endpackage

//--- core_ctrl_pkg.sv
package core_ctrl_pkg;

    // ********************************************************************
    // ALU operations
    // ********************************************************************
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_copy_b    // Passes operand b through, used by lui
    } alu_op_e;

    typedef enum logic {
        wb_alu,
        wb_csr        // Old CSR value for csrrw
    } wb_src_e;

endpackage

//--- core_ex_if.sv
`timescale 1ns/1ps

interface core_ex_if;
    import core_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [xlen-1:0] inst;
    logic [xlen-1:0] alu_src1;
    logic [xlen-1:0] alu_src2;
    alu_op_e         alu_ctrl;
    logic [xlen-1:0] imm_i;            // Branch or jump offset
    logic [xlen-1:0] pc_adder_src2;    // pc, or rs1 for jalr

    modport dec (
        output inst, alu_src1, alu_src2, alu_ctrl, imm_i, pc_adder_src2
    );

    modport exe (
        input inst, alu_src1, alu_src2, alu_ctrl, imm_i, pc_adder_src2
    );

endinterface

//--- fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter logic [core_isa_pkg::xlen-1:0] reset_pc   = 32'h0,
    parameter int                            imem_depth = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          run,
    input  logic                          imem_we,
    input  logic [$clog2(imem_depth)-1:0] imem_addr,
    input  logic [core_isa_pkg::xlen-1:0] imem_wdata,
    input  logic [core_isa_pkg::xlen-1:0] dnpc,
    output logic [core_isa_pkg::xlen-1:0] pc,
    output logic [core_isa_pkg::xlen-1:0] inst
);
    import core_isa_pkg::*;

    localparam int aw = $clog2(imem_depth);

    logic [xlen-1:0] imem [imem_depth];

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (run) begin
            pc <= dnpc;    // Holds while the core is stopped
        end
    end

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    assign inst = imem[pc[aw+1:2]];    // Word addressed, asynchronous read

endmodule

//--- decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic                          run,
    input  logic [core_isa_pkg::xlen-1:0] pc,
    input  logic [core_isa_pkg::xlen-1:0] inst,
    input  logic [core_isa_pkg::xlen-1:0] rs1_data,
    input  logic [core_isa_pkg::xlen-1:0] rs2_data,
    output logic [4:0]                    rs1_addr,
    output logic [4:0]                    rs2_addr,
    output logic                          rd_we,
    output logic [4:0]                    rd_addr,
    output core_ctrl_pkg::wb_src_e        wb_src,
    output logic [11:0]                   csr_addr,
    output logic                          csr_we,
    output logic                          is_ecall,
    output logic                          is_mret,
    core_ex_if.dec                        ex_if
);
    import core_isa_pkg::*;
    import core_ctrl_pkg::*;

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [xlen-1:0] imm_i_type;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic            ecall_hit;
    logic            rd_write;
    logic            csr_write;
    alu_op_e         alu_fn;

    assign opcode   = opcode_e'(inst[6:0]);
    assign funct3   = inst[14:12];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];
    assign rd_addr  = inst[11:7];

    assign imm_i_type = {{20{inst[31]}}, inst[31:20]};
    assign imm_u      = {inst[31:12], 12'b0};
    assign imm_b      = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j      = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    assign ecall_hit = (inst == inst_ecall);
    assign is_mret   = (inst == inst_mret);
    assign ex_if.inst = inst;

    // ********************************************************************
    // ALU function for register and immediate forms
    // ********************************************************************
    always_comb begin
        case (funct3)
            f3_add_sub: alu_fn = (opcode == op_reg && inst[30]) ? alu_sub : alu_add;
            f3_sll:     alu_fn = alu_sll;
            f3_slt:     alu_fn = alu_slt;
            f3_sltu:    alu_fn = alu_sltu;
            f3_xor:     alu_fn = alu_xor;
            f3_srl_sra: alu_fn = inst[30] ? alu_sra : alu_srl;    // srai shares bit 30
            f3_or:      alu_fn = alu_or;
            default:    alu_fn = alu_and;
        endcase
    end

    always_comb begin
        ex_if.alu_src1      = rs1_data;
        ex_if.alu_src2      = rs2_data;
        ex_if.alu_ctrl      = alu_add;
        ex_if.imm_i         = imm_i_type;
        ex_if.pc_adder_src2 = pc;
        rd_write            = 1'b0;
        csr_write           = 1'b0;
        wb_src              = wb_alu;
        csr_addr            = inst[31:20];
        case (opcode)
            op_reg: begin
                ex_if.alu_ctrl = alu_fn;
                rd_write       = 1'b1;
            end
            op_imm: begin
                ex_if.alu_src2 = imm_i_type;
                ex_if.alu_ctrl = alu_fn;
                rd_write       = 1'b1;
            end
            op_lui: begin
                ex_if.alu_src2 = imm_u;
                ex_if.alu_ctrl = alu_copy_b;
                rd_write       = 1'b1;
            end
            op_auipc: begin
                ex_if.alu_src1 = pc;
                ex_if.alu_src2 = imm_u;
                rd_write       = 1'b1;
            end
            op_jal: begin
                ex_if.alu_src1 = pc;    // Link value is pc + 4
                ex_if.alu_src2 = 32'd4;
                ex_if.imm_i    = imm_j;
                rd_write       = 1'b1;
            end
            op_jalr: begin
                ex_if.alu_src1      = pc;
                ex_if.alu_src2      = 32'd4;
                ex_if.pc_adder_src2 = rs1_data;
                rd_write            = 1'b1;
            end
            op_branch: begin
                ex_if.imm_i = imm_b;
                case (funct3)
                    f3_beq, f3_bne: ex_if.alu_ctrl = alu_sub;
                    f3_blt, f3_bge: ex_if.alu_ctrl = alu_slt;
                    default:        ex_if.alu_ctrl = alu_sltu;
                endcase
            end
            op_system: begin
                if (ecall_hit) begin
                    csr_addr = csr_mtvec;    // Trap target read for the next pc
                end else if (is_mret) begin
                    csr_addr = csr_mepc;
                end else if (funct3 == f3_csrrw) begin
                    rd_write  = 1'b1;
                    csr_write = 1'b1;
                    wb_src    = wb_csr;
                end
            end
            default: begin
                rd_write = 1'b0;    // Unsupported opcodes fall through as a no-op
            end
        endcase
    end

    assign rd_we    = run && rd_write && (rd_addr != 5'd0);
    assign csr_we   = run && csr_write;
    assign is_ecall = run && ecall_hit;

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [4:0]                    rs1_addr,
    input  logic [4:0]                    rs2_addr,
    input  logic                          rd_we,
    input  logic [4:0]                    rd_addr,
    input  core_ctrl_pkg::wb_src_e        wb_src,
    input  logic [core_isa_pkg::xlen-1:0] alu_result,
    input  logic [core_isa_pkg::xlen-1:0] csr_rdata,
    output logic [core_isa_pkg::xlen-1:0] rs1_data,
    output logic [core_isa_pkg::xlen-1:0] rs2_data
);
    import core_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [xlen-1:0] regs [32];
    logic [xlen-1:0] rd_wdata;

    assign rd_wdata = (wb_src == wb_csr) ? csr_rdata : alu_result;

    always_ff @(posedge clk) begin
        if (!reset && rd_we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_wdata;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];    // x0 reads as zero
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

//--- csr_unit.sv
`timescale 1ns/1ps

module csr_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [core_isa_pkg::xlen-1:0] pc,
    input  logic [11:0]                   csr_addr,
    input  logic                          csr_we,
    input  logic [core_isa_pkg::xlen-1:0] csr_wdata,
    input  logic                          is_ecall,
    input  logic                          is_mret,
    output logic [core_isa_pkg::xlen-1:0] csr_rdata
);
    import core_isa_pkg::*;

    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;

    always_comb begin
        if (is_mret) begin
            csr_rdata = mepc;    // Return target
        end else begin
            case (csr_addr)
                csr_mtvec:  csr_rdata = mtvec;
                csr_mepc:   csr_rdata = mepc;
                csr_mcause: csr_rdata = mcause;
                default:    csr_rdata = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mtvec  <= '0;
            mepc   <= '0;
            mcause <= '0;
        end else if (is_ecall) begin
            mepc   <= pc;    // Trap entry saves the ecall address
            mcause <= cause_ecall_m;
        end else if (csr_we) begin
            case (csr_addr)
                csr_mtvec:  mtvec  <= csr_wdata;
                csr_mepc:   mepc   <= csr_wdata;
                csr_mcause: mcause <= csr_wdata;
                default:    mtvec  <= mtvec;
            endcase
        end
    end

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [core_isa_pkg::xlen-1:0] a,
    input  logic [core_isa_pkg::xlen-1:0] b,
    input  core_ctrl_pkg::alu_op_e        ctrl,
    output logic [core_isa_pkg::xlen-1:0] result,
    output logic                          zero_flag,
    output logic                          less_flag
);
    import core_isa_pkg::*;
    import core_ctrl_pkg::*;

    always_comb begin
        case (ctrl)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << b[4:0];
            alu_slt:    result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu:   result = {{(xlen-1){1'b0}}, a < b};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> b[4:0];
            alu_sra:    result = $unsigned($signed(a) >>> b[4:0]);
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_copy_b: result = b;
            default:    result = '0;
        endcase
    end

    assign zero_flag = (result == '0);
    assign less_flag = result[0];    // Only meaningful after slt or sltu

endmodule

//--- ex.sv
`timescale 1ns/1ps

module ex (
    core_ex_if.exe                        ex_if,
    input  logic [core_isa_pkg::xlen-1:0] csr_rdata,
    output logic [core_isa_pkg::xlen-1:0] alu_result,
    output logic [core_isa_pkg::xlen-1:0] dnpc
);
    import core_isa_pkg::*;

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic            zero_flag;
    logic            less_flag;
    logic            taken;
    logic            trap_jump;
    logic [xlen-1:0] pc_adder_src1;
    logic [xlen-1:0] pc_sum;

    assign opcode    = opcode_e'(ex_if.inst[6:0]);
    assign funct3    = ex_if.inst[14:12];
    assign trap_jump = (ex_if.inst == inst_ecall) || (ex_if.inst == inst_mret);

    // ********************************************************************
    // Branch decision and pc adder
    // ********************************************************************
    always_comb begin
        case (funct3)
            f3_beq:          taken = zero_flag;
            f3_bne:          taken = !zero_flag;
            f3_blt, f3_bltu: taken = less_flag;
            f3_bge, f3_bgeu: taken = !less_flag;
            default:         taken = 1'b0;
        endcase
    end

    always_comb begin
        case (opcode)
            op_jal, op_jalr: pc_adder_src1 = ex_if.imm_i;
            op_branch:       pc_adder_src1 = taken ? ex_if.imm_i : xlen'(4);
            default:         pc_adder_src1 = xlen'(4);
        endcase
    end

    assign pc_sum = pc_adder_src1 + ex_if.pc_adder_src2;
    assign dnpc   = trap_jump ? csr_rdata :
                    (opcode == op_jalr) ? {pc_sum[xlen-1:1], 1'b0} : pc_sum;

    alu u_alu (
        .a         (ex_if.alu_src1),
        .b         (ex_if.alu_src2),
        .ctrl      (ex_if.alu_ctrl),
        .result    (alu_result),
        .zero_flag (zero_flag),
        .less_flag (less_flag)
    );

endmodule

//--- core_top.sv
`timescale 1ns/1ps

module core_top #(
    parameter logic [core_isa_pkg::xlen-1:0] reset_pc   = 32'h0,
    parameter int                            imem_depth = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          run,
    input  logic                          imem_we,
    input  logic [$clog2(imem_depth)-1:0] imem_addr,
    input  logic [core_isa_pkg::xlen-1:0] imem_wdata,
    output logic                          retire_valid,
    output logic [core_isa_pkg::xlen-1:0] retire_pc,
    output logic [core_isa_pkg::xlen-1:0] retire_inst,
    output logic                          retire_rd_we,
    output logic [4:0]                    retire_rd_addr,
    output logic [core_isa_pkg::xlen-1:0] retire_rd_wdata,
    output logic [core_isa_pkg::xlen-1:0] retire_next_pc
);
    import core_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
    logic [xlen-1:0] dnpc;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic            rd_we;
    logic [4:0]      rd_addr;
    wb_src_e         wb_src;
    logic [11:0]     csr_addr;
    logic            csr_we;
    logic            is_ecall;
    logic            is_mret;
    logic [xlen-1:0] csr_rdata;
    logic [xlen-1:0] alu_result;

    core_ex_if ex_bus ();

    fetch_unit #(
        .reset_pc   (reset_pc),
        .imem_depth (imem_depth)
    ) u_fetch_unit (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .dnpc       (dnpc),
        .pc         (pc),
        .inst       (inst)
    );

    decoder u_decoder (
        .run      (run),
        .pc       (pc),
        .inst     (inst),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_we    (rd_we),
        .rd_addr  (rd_addr),
        .wb_src   (wb_src),
        .csr_addr (csr_addr),
        .csr_we   (csr_we),
        .is_ecall (is_ecall),
        .is_mret  (is_mret),
        .ex_if    (ex_bus.dec)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .reset      (reset),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rd_we      (rd_we),
        .rd_addr    (rd_addr),
        .wb_src     (wb_src),
        .alu_result (alu_result),
        .csr_rdata  (csr_rdata),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    csr_unit u_csr_unit (
        .clk       (clk),
        .reset     (reset),
        .pc        (pc),
        .csr_addr  (csr_addr),
        .csr_we    (csr_we),
        .csr_wdata (rs1_data),    // csrrw writes rs1
        .is_ecall  (is_ecall),
        .is_mret   (is_mret),
        .csr_rdata (csr_rdata)
    );

    ex u_ex (
        .ex_if      (ex_bus.exe),
        .csr_rdata  (csr_rdata),
        .alu_result (alu_result),
        .dnpc       (dnpc)
    );

    // ********************************************************************
    // Retire ports describe the instruction at the current pc
    // ********************************************************************
    assign retire_valid    = run;
    assign retire_pc       = pc;
    assign retire_inst     = inst;
    assign retire_rd_we    = rd_we;
    assign retire_rd_addr  = rd_addr;
    assign retire_rd_wdata = (wb_src == wb_csr) ? csr_rdata : alu_result;
    assign retire_next_pc  = dnpc;

endmodule

//--- tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ********************************************************************
// Instruction-level RV32I model, one step per retired instruction
// ********************************************************************
logic [31:0] m_pc;
logic [31:0] m_regs [32];
logic [31:0] m_mtvec;
logic [31:0] m_mepc;
logic [31:0] m_mcause;
logic [31:0] exp_pc;
logic [31:0] exp_next_pc;
logic [31:0] exp_wdata;
logic [4:0]  exp_rd_addr;
logic        exp_rd_we;

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        default: return a >= b;
    endcase
endfunction

function automatic logic [31:0] csr_read(input logic [11:0] addr);
    case (addr)
        12'h305: return m_mtvec;
        12'h341: return m_mepc;
        12'h342: return m_mcause;
        default: return 32'd0;
    endcase
endfunction

task automatic model_step(input logic [31:0] inst);
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] res;
    logic [31:0] npc;
    logic        we;
    rd    = inst[11:7];
    a     = (inst[19:15] == 5'd0) ? 32'd0 : m_regs[inst[19:15]];
    b     = (inst[24:20] == 5'd0) ? 32'd0 : m_regs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    res   = 32'd0;
    we    = 1'b0;
    npc   = m_pc + 32'd4;
    case (inst[6:0])
        7'h33: begin
            we  = 1'b1;
            res = alu_ref(inst[14:12], inst[30], a, b);
        end
        7'h13: begin
            we  = 1'b1;
            res = alu_ref(inst[14:12], inst[30] && inst[14:12] == 3'd5, a, imm_i);
        end
        7'h37: begin
            we  = 1'b1;
            res = {inst[31:12], 12'b0};
        end
        7'h17: begin
            we  = 1'b1;
            res = m_pc + {inst[31:12], 12'b0};
        end
        7'h6f: begin
            we  = 1'b1;
            res = m_pc + 32'd4;
            npc = m_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        7'h67: begin
            we  = 1'b1;
            res = m_pc + 32'd4;
            npc = (a + imm_i) & ~32'd1;
        end
        7'h63: begin
            if (branch_ref(inst[14:12], a, b)) begin
                npc = m_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
        end
        7'h73: begin
            if (inst == 32'h0000_0073) begin
                npc      = m_mtvec;    // Trap entry
                m_mepc   = m_pc;
                m_mcause = 32'd11;
            end else if (inst == 32'h3020_0073) begin
                npc = m_mepc;
            end else if (inst[14:12] == 3'd1) begin
                we  = 1'b1;
                res = csr_read(inst[31:20]);
                case (inst[31:20])
                    12'h305: m_mtvec  = a;
                    12'h341: m_mepc   = a;
                    12'h342: m_mcause = a;
                    default: m_mtvec  = m_mtvec;
                endcase
            end
        end
        default: we = 1'b0;
    endcase
    exp_rd_we   = we && (rd != 5'd0);
    exp_rd_addr = rd;
    exp_wdata   = res;
    exp_next_pc = npc;
    if (exp_rd_we) begin
        m_regs[rd] = res;
    end
    m_pc = npc;
endtask

`endif

//--- tb_core_top.sv
`timescale 1ns/1ps

module tb_core_top;

    logic        clk;
    logic        reset;
    logic        run;
    logic        imem_we;
    logic [7:0]  imem_addr;
    logic [31:0] imem_wdata;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [31:0] retire_inst;
    logic        retire_rd_we;
    logic [4:0]  retire_rd_addr;
    logic [31:0] retire_rd_wdata;
    logic [31:0] retire_next_pc;

    logic [31:0] prog [$];
    logic [31:0] end_pc;
    logic [31:0] exp_inst;
    logic        done;
    integer      seed;
    int          errors;

    `include "tb_ref_model.svh"

    core_top #(
        .reset_pc   (32'h0),
        .imem_depth (256)
    ) u_core_top (
        .clk             (clk),
        .reset           (reset),
        .run             (run),
        .imem_we         (imem_we),
        .imem_addr       (imem_addr),
        .imem_wdata      (imem_wdata),
        .retire_valid    (retire_valid),
        .retire_pc       (retire_pc),
        .retire_inst     (retire_inst),
        .retire_rd_we    (retire_rd_we),
        .retire_rd_addr  (retire_rd_addr),
        .retire_rd_wdata (retire_rd_wdata),
        .retire_next_pc  (retire_next_pc)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    // ********************************************************************
    // Program with register init, branches, jumps, a CSR trap and random ALU ops
    // ********************************************************************
    task automatic build_program();
        logic [2:0]  f3s [6];
        logic [31:0] r;
        logic [31:0] r2;
        logic [2:0]  f3;
        logic        alt;
        f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        for (int i = 1; i < 32; i++) begin
            prog.push_back(enc_i((i == 1) ? -12'sd5 : 12'(i * 3), 5'd0, 3'd0, 5'(i), 7'h13));
        end
        foreach (f3s[k]) begin
            for (int p = 0; p < 3; p++) begin    // Equal, a-b and b-a give both outcomes
                prog.push_back(enc_b(13'd8, (p == 1) ? 5'd2 : 5'd1, (p == 2) ? 5'd2 : 5'd1,
                                     f3s[k]));
                prog.push_back(enc_i(12'd1, 5'd5, 3'd0, 5'd5, 7'h13));
            end
        end
        prog.push_back(enc_j(21'd8, 5'd6));
        prog.push_back(enc_i(12'd1, 5'd5, 3'd0, 5'd5, 7'h13));
        prog.push_back({20'h0, 5'd7, 7'h17});
        prog.push_back(enc_i(12'd13, 5'd7, 3'd0, 5'd8, 7'h67));    // Odd target tests bit 0
        prog.push_back(enc_i(12'd1, 5'd5, 3'd0, 5'd5, 7'h13));
        prog.push_back({20'h12345, 5'd9, 7'h37});
        prog.push_back({20'h0, 5'd10, 7'h17});
        prog.push_back(enc_i(12'd20, 5'd10, 3'd0, 5'd10, 7'h13));
        prog.push_back(enc_i(12'h305, 5'd10, 3'd1, 5'd11, 7'h73));
        prog.push_back(32'h0000_0073);
        prog.push_back(enc_j(21'd24, 5'd0));    // mret lands here, then skips the handler
        prog.push_back(enc_i(12'h342, 5'd0, 3'd1, 5'd13, 7'h73));
        prog.push_back(enc_i(12'h341, 5'd0, 3'd1, 5'd12, 7'h73));
        prog.push_back(enc_i(12'd4, 5'd12, 3'd0, 5'd12, 7'h13));
        prog.push_back(enc_i(12'h341, 5'd12, 3'd1, 5'd0, 7'h73));
        prog.push_back(32'h3020_0073);
        for (int n = 0; n < 40; n++) begin
            r   = $random(seed);
            r2  = $random(seed);
            f3  = r[17:15];
            alt = r[18] && (f3 == 3'd0 || f3 == 3'd5);
            if (r[21:19] == 3'd0) begin
                prog.push_back({r2[31:12], r[4:0], 7'h37});
            end else if (r[21:19] == 3'd1) begin
                prog.push_back({r2[31:12], r[4:0], 7'h17});
            end else if (r[19]) begin
                prog.push_back(enc_r(alt ? 7'h20 : 7'h00, r[14:10], r[9:5], f3, r[4:0]));
            end else if (f3 == 3'd1 || f3 == 3'd5) begin
                prog.push_back(enc_i({1'b0, alt && f3 == 3'd5, 5'd0, r2[4:0]}, r[9:5], f3,
                                     r[4:0], 7'h13));
            end else begin
                prog.push_back(enc_i(r2[31:20], r[9:5], f3, r[4:0], 7'h13));
            end
        end
        end_pc = 32'(prog.size() * 4);
        prog.push_back(enc_j(21'd0, 5'd0));    // Self loop marks the end
    endtask

    always @(negedge clk) begin
        if (!reset && run && !done) begin
            exp_pc   = m_pc;
            exp_inst = prog[m_pc[31:2]];
            model_step(exp_inst);
            if (exp_pc == end_pc) begin
                done = 1'b1;
            end
        end
    end

    // ********************************************************************
    // Checks on the retire ports
    // ********************************************************************
    a_idle: assert property (@(posedge clk) (reset || !run) |-> !retire_valid && !retire_rd_we)
        else begin
            errors++;
            $display("error %0t: retire active while idle", $time);
        end
    a_first_pc: assert property (@(posedge clk) disable iff (reset)
                                 $rose(run) |-> retire_pc == 32'h0)
        else begin
            errors++;
            $display("error %0t: first pc %h", $time, retire_pc);
        end
    a_pc: assert property (@(posedge clk) disable iff (reset) run |-> retire_pc == exp_pc)
        else begin
            errors++;
            $display("error %0t: pc %h exp %h", $time, retire_pc, exp_pc);
        end
    a_inst: assert property (@(posedge clk) disable iff (reset)
                             run |-> retire_valid && retire_inst == exp_inst)
        else begin
            errors++;
            $display("error %0t: valid %b inst %h exp %h", $time, retire_valid, retire_inst,
                     exp_inst);
        end
    a_wdata: assert property (@(posedge clk) disable iff (reset) run && exp_rd_we |->
                              retire_rd_we && retire_rd_addr == exp_rd_addr &&
                              retire_rd_wdata == exp_wdata)
        else begin
            errors++;
            $display("error %0t: pc %h x%0d = %h exp %h", $time, retire_pc, retire_rd_addr,
                     retire_rd_wdata, exp_wdata);
        end
    a_no_write: assert property (@(posedge clk) disable iff (reset)
                                 run && !exp_rd_we |-> !retire_rd_we)
        else begin
            errors++;
            $display("error %0t: unexpected write at %h", $time, retire_pc);
        end
    a_next_pc: assert property (@(posedge clk) disable iff (reset)
                                run |-> retire_next_pc == exp_next_pc)
        else begin
            errors++;
            $display("error %0t: next pc %h exp %h", $time, retire_next_pc, exp_next_pc);
        end
    a_seq: assert property (@(posedge clk) disable iff (reset)
                            run && $past(run) |-> retire_pc == $past(retire_next_pc))
        else begin
            errors++;
            $display("error %0t: pc sequence broken", $time);
        end

    initial begin
        wait (run === 1'b1);
        #((prog.size() + 20) * 8);
        if (!done) begin
            $display("timeout: the program did not finish, errors %0d", errors);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        done       = 1'b0;
        errors     = 0;
        seed       = 32'hef6;
        m_pc       = 32'h0;
        m_mtvec    = '0;
        m_mepc     = '0;
        m_mcause   = '0;
        exp_pc     = '0;
        exp_inst   = '0;
        exp_rd_we  = 1'b0;
        foreach (m_regs[i]) begin
            m_regs[i] = '0;
        end
        build_program();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        foreach (prog[i]) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= 8'(i);
            imem_wdata <= prog[i];
        end
        @(posedge clk);
        imem_we <= 1'b0;
        @(posedge clk);
        run <= 1'b1;
        wait (done);
        @(posedge clk);
        run <= 1'b0;
        repeat (2) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+.
core_isa_pkg.sv
core_ctrl_pkg.sv
core_ex_if.sv
fetch_unit.sv
decoder.sv
reg_file.sv
csr_unit.sv
alu.sv
ex.sv
core_top.sv
tb_core_top.sv

//--- Bender.yml
package:
  name: rv32i_core

sources:
  - files:
      - core_isa_pkg.sv
      - core_ctrl_pkg.sv
      - core_ex_if.sv
      - fetch_unit.sv
      - decoder.sv
      - reg_file.sv
      - csr_unit.sv
      - alu.sv
      - ex.sv
      - core_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_core_top.sv
